/* verilog.f */
stream_pkg.sv
wb_pkg.sv
fifo_if.sv
sync_fifo.sv
wb_frame_port.sv
frame_checksum.sv
stream_buffer_top.sv
stream_buffer_assert.sv
tb_stream_buffer.sv

/* tb_stream_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stream_buffer;
    import stream_pkg::*;
    import wb_pkg::*;

    localparam int KEPT_FRAMES   = RESULT_DEPTH + 1 + DATA_DEPTH;
    localparam int ACK_TIMEOUT   = 16;
    localparam int DRAIN_TIMEOUT = 4000;
    localparam logic [DAT_W-1:0] STATUS_IDLE = DAT_W'((1 << STAT_EMPTY) | (1 << STAT_AEMPTY));
    localparam logic [DAT_W-1:0] STATUS_OVF  = DAT_W'(1 << STAT_OVERFLOW);
    localparam logic [DAT_W-1:0] STATUS_STALLED = DAT_W'((DATA_DEPTH << STAT_LEVEL_LSB)
        | (1 << STAT_AFULL) | (1 << STAT_FULL) | (1 << STAT_OVERFLOW));

    logic             clk;
    logic             rst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [ADR_W-1:0] wb_adr;
    logic [DAT_W-1:0] wb_dat_w;
    logic [DAT_W-1:0] wb_dat_r;
    logic             wb_ack;
    logic             out_valid;
    logic [15:0]      out_sum;
    logic [7:0]       out_len;
    logic             out_ready;

    // 0 keeps out_ready high, 1 drops it now and then, 2 holds it low.
    int               ready_mode;
    int               errors;
    int               tests_run;
    int               tests_bad;
    frame_result_t    expected_q[$];

    stream_buffer_top uut (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .out_valid(out_valid), .out_sum(out_sum), .out_len(out_len), .out_ready(out_ready)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // out_valid is stable here, so a result seen with out_ready set is taken next edge.
    always @(negedge clk) begin : collect
        frame_result_t exp_res;
        if (!rst_n) begin
            out_ready = 1'b0;
        end else begin
            case (ready_mode)
                0:       out_ready = 1'b1;
                1:       out_ready = ($urandom % 4) != 0;
                default: out_ready = 1'b0;
            endcase
            if (out_ready && out_valid) begin
                if (expected_q.size() == 0) begin
                    $display("unexpected result with sum 0x%h and length 0x%h", out_sum, out_len);
                    errors++;
                end else begin
                    exp_res = expected_q.pop_front();
                    assert (out_sum == exp_res.sum) else begin
                        $display("ERROR out_sum: got 0x%h, expected 0x%h", out_sum, exp_res.sum);
                        errors++;
                    end
                    assert (out_len == exp_res.len) else begin
                        $display("ERROR out_len: got 0x%h, expected 0x%h", out_len, exp_res.len);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [DAT_W-1:0] dat, output logic [DAT_W-1:0] rdata);
        int waited;
        waited = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge clk);
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) begin
            $display("timeout: no wb_ack for the access to address %0d", adr);
            errors++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // the model entry goes in first, since the result may appear soon after the last ack.
    task automatic send_frame(input int len, input bit keep);
        logic [7:0]       bytes [$];
        logic [DAT_W-1:0] rdata;
        frame_result_t    res;
        res.sum = '0;
        res.len = 8'(len);
        for (int i = 0; i < len; i++) begin
            bytes.push_back(8'($urandom));
            res.sum = res.sum + 16'(bytes[i]);
        end
        if (keep) begin
            expected_q.push_back(res);
        end
        for (int i = 0; i < len; i++) begin
            wb_access(1'b1, (i == len - 1) ? ADR_LAST : ADR_DATA,
                      {8'($urandom), bytes[i]}, rdata);
        end
    endtask

    task automatic check_status(input logic [DAT_W-1:0] expected);
        logic [DAT_W-1:0] rdata;
        wb_access(1'b0, ADR_STATUS, '0, rdata);
        assert (rdata == expected) else begin
            $display("ERROR wb_dat_r: got 0x%h, expected 0x%h", rdata, expected);
            errors++;
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("timeout: %0d expected results never came out", expected_q.size());
            errors++;
            expected_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: FAILED", tests_run, name);
        end
    endtask

    initial begin
        int               mark;
        logic [DAT_W-1:0] rdata;
        void'($urandom(7402));
        {wb_cyc, wb_stb, wb_we, out_ready} = '0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        ready_mode = 0;
        errors     = 0;
        tests_run  = 0;
        tests_bad  = 0;
        rst_n      = 1'b0;
        // three rising edges pass with reset held, then it is released on a falling edge.
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        assert (!out_valid && !wb_ack) else begin
            $display("ERROR out_valid/wb_ack: got 0x%h/0x%h, expected 0x0/0x0", out_valid, wb_ack);
            errors++;
        end
        check_status(STATUS_IDLE);
        report_test("reset state", mark);

        mark = errors;
        send_frame(1 + $urandom % 32, 1'b1);
        wait_drained();
        report_test("single frame", mark);

        mark = errors;
        ready_mode = 1;
        repeat (20) send_frame(1 + $urandom % 24, 1'b1);
        wait_drained();
        ready_mode = 0;
        check_status(STATUS_IDLE);
        report_test("random frames with back-pressure", mark);

        mark = errors;
        ready_mode = 2;
        for (int i = 0; i < KEPT_FRAMES + 3; i++) begin
            send_frame(1, i < KEPT_FRAMES);
        end
        check_status(STATUS_STALLED);
        ready_mode = 0;
        wait_drained();
        report_test("overflow with output stalled", mark);

        mark = errors;
        check_status(STATUS_IDLE | STATUS_OVF);
        wb_access(1'b1, ADR_STATUS, '0, rdata);
        check_status(STATUS_IDLE);
        assert (!out_valid) else begin
            $display("ERROR out_valid: got 0x%h, expected 0x0", out_valid);
            errors++;
        end
        report_test("overflow clear", mark);

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* stream_buffer_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_buffer_assert (
    input logic clk,
    input logic rst_n,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic push,
    input logic full,
    input logic empty,
    input logic overflow
);

    ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(cyc && stb))
        else $error("wb_ack rose without cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> !ack)
        else $error("wb_ack stayed high for more than one cycle");

    full_empty_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(full && empty))
        else $error("FIFO full and empty at the same time");

    overflow_cause: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |-> (push && full))
        else $error("overflow without a push into a full FIFO");

endmodule

// a FIFO has no Wishbone side, so its bus inputs are tied idle.
bind sync_fifo stream_buffer_assert u_fifo_assert (
    .clk(clk), .rst_n(rst_n), .cyc(1'b0), .stb(1'b0), .ack(1'b0),
    .push(wr.push), .full(wr.full), .empty(rd.empty), .overflow(overflow)
);

bind wb_frame_port stream_buffer_assert u_port_assert (
    .clk(clk), .rst_n(rst_n), .cyc(wb_cyc), .stb(wb_stb), .ack(wb_ack),
    .push(data_push.push), .full(data_push.full), .empty(empty), .overflow(overflow)
);

`default_nettype wire

/* stream_buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_buffer_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [wb_pkg::ADR_W-1:0] wb_adr,
    input  logic [wb_pkg::DAT_W-1:0] wb_dat_w,
    output logic [wb_pkg::DAT_W-1:0] wb_dat_r,
    output logic                     wb_ack,
    output logic                     out_valid,
    output logic [15:0]              out_sum,
    output logic [7:0]               out_len,
    input  logic                     out_ready
);
    import stream_pkg::*;

    logic [DATA_LEVEL_W-1:0] data_level;
    logic                    data_overflow;

    fifo_if #(.payload_t(byte_entry_t))   data_if ();
    fifo_if #(.payload_t(frame_result_t)) result_if ();

    wb_frame_port u_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .data_push    (data_if.producer),
        .level        (data_level),
        .empty        (data_if.empty),
        .almost_empty (data_if.almost_empty),
        .overflow     (data_overflow)
    );

    sync_fifo #(
        .payload_t (byte_entry_t),
        .DEPTH     (DATA_DEPTH)
    ) u_data_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (data_if.fifo_wr),
        .rd        (data_if.fifo_rd),
        .level     (data_level),
        .overflow  (data_overflow),
        .underflow ()
    );

    frame_checksum u_checksum (
        .clk   (clk),
        .rst_n (rst_n),
        .src   (data_if.consumer),
        .dst   (result_if.producer)
    );

    // the checksum stage never pushes into a full result FIFO.
    sync_fifo #(
        .payload_t (frame_result_t),
        .DEPTH     (RESULT_DEPTH)
    ) u_result_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (result_if.fifo_wr),
        .rd        (result_if.fifo_rd),
        .level     (),
        .overflow  (),
        .underflow ()
    );

    assign out_valid     = !result_if.empty;
    assign result_if.pop = out_valid && out_ready;
    assign out_sum       = result_if.pop_data.sum;
    assign out_len       = result_if.pop_data.len;

endmodule

`default_nettype wire

/* frame_checksum.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_checksum (
    input  logic     clk,
    input  logic     rst_n,
    fifo_if.consumer src,
    fifo_if.producer dst
);
    import stream_pkg::*;

    logic [15:0]   sum_acc;
    logic [7:0]    len_acc;
    logic [15:0]   sum_next;
    logic [7:0]    len_next;
    logic          take;
    logic          pend_valid;
    frame_result_t pend;
    byte_entry_t   entry;

    assign entry = src.pop_data;

    // no byte is taken while a finished frame still waits for room.
    assign take = !src.empty && !pend_valid;

    assign sum_next = sum_acc + {8'd0, entry.data};
    assign len_next = len_acc + 8'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_acc <= '0;
            len_acc <= '0;
        end else if (take) begin
            if (entry.last) begin
                sum_acc <= '0;
                len_acc <= '0;
            end else begin
                sum_acc <= sum_next;
                len_acc <= len_next;
            end
        end
    end

    // take implies no pending result, so set and clear never meet.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else if (take && entry.last) begin
            pend_valid <= 1'b1;
        end else if (dst.push) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && entry.last) begin
            pend.sum <= sum_next;
            pend.len <= len_next;
        end
    end

    assign src.pop       = take;
    assign dst.push      = pend_valid && !dst.full;
    assign dst.push_data = pend;

endmodule

`default_nettype wire

/* wb_frame_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_frame_port (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [wb_pkg::ADR_W-1:0]            wb_adr,
    input  logic [wb_pkg::DAT_W-1:0]            wb_dat_w,
    output logic [wb_pkg::DAT_W-1:0]            wb_dat_r,
    output logic                                wb_ack,
    fifo_if.producer                            data_push,
    input  logic [stream_pkg::DATA_LEVEL_W-1:0] level,
    input  logic                                empty,
    input  logic                                almost_empty,
    input  logic                                overflow
);
    import wb_pkg::*;
    import stream_pkg::*;

    logic             req;
    logic             wr_byte;
    logic             clr_ovf;
    logic             ovf_sticky;
    logic [DAT_W-1:0] status;
    byte_entry_t      entry;

    // a new access is one the port has not yet acknowledged.
    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign wr_byte = req && wb_we && (wb_adr == ADR_DATA || wb_adr == ADR_LAST);
    assign clr_ovf = req && wb_we && (wb_adr == ADR_STATUS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // the sticky bit catches bytes lost to a full data FIFO.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_sticky <= 1'b0;
        end else if (overflow) begin
            ovf_sticky <= 1'b1;
        end else if (clr_ovf) begin
            ovf_sticky <= 1'b0;
        end
    end

    always_comb begin
        status = '0;
        status[STAT_LEVEL_LSB +: STAT_LEVEL_W] = level;
        status[STAT_EMPTY]    = empty;
        status[STAT_AEMPTY]   = almost_empty;
        status[STAT_AFULL]    = data_push.almost_full;
        status[STAT_FULL]     = data_push.full;
        status[STAT_OVERFLOW] = ovf_sticky;
    end

    // read data is captured with the ack and only means something while ack is high.
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= (wb_adr == ADR_STATUS) ? status : '0;
        end
    end

    assign entry.data = wb_dat_w[7:0];
    assign entry.last = (wb_adr == ADR_LAST);

    // the byte enters the FIFO on the edge that raises ack.
    assign data_push.push      = wr_byte;
    assign data_push.push_data = entry;

endmodule

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = stream_pkg::DATA_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    fifo_if.fifo_wr                    wr,
    fifo_if.fifo_rd                    rd,
    output logic [$clog2(DEPTH+1)-1:0] level,
    output logic                       overflow,
    output logic                       underflow
);
    import stream_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = wr.push && !wr.full;
    assign do_pop  = rd.pop && !rd.empty;

    // a push and a pop in the same cycle leave the occupancy as it is.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.push_data;
        end
    end

    // the head entry is shown as soon as it is written.
    assign rd.pop_data = mem[rd_ptr];

    assign wr.full         = (count == CNT_W'(DEPTH));
    assign wr.almost_full  = (count >= CNT_W'(DEPTH - AFULL_LEVEL));
    assign rd.empty        = (count == '0);
    assign rd.almost_empty = (count <= CNT_W'(AEMPTY_LEVEL));

    assign level     = count;
    assign overflow  = wr.push && wr.full;
    assign underflow = rd.pop && rd.empty;

endmodule

`default_nettype wire

/* fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
    parameter type payload_t = logic
);

    logic     push;
    payload_t push_data;
    logic     full;
    logic     almost_full;

    logic     pop;
    payload_t pop_data;
    logic     empty;
    logic     almost_empty;

    // producer and consumer are the views of the FIFO's neighbours.
    modport producer (output push, push_data, input full, almost_full);
    modport consumer (output pop, input pop_data, empty, almost_empty);

    // the FIFO itself sees both sides with the directions turned around.
    modport fifo_wr (input push, push_data, output full, almost_full);
    modport fifo_rd (input pop, output pop_data, empty, almost_empty);

endinterface

`default_nettype wire

/* wb_pkg.sv */
`default_nettype none

package wb_pkg;

    localparam int ADR_W = 2;
    localparam int DAT_W = 16;

    // register map.
    localparam logic [ADR_W-1:0] ADR_DATA   = 2'd0;
    localparam logic [ADR_W-1:0] ADR_LAST   = 2'd1;
    localparam logic [ADR_W-1:0] ADR_STATUS = 2'd2;

    // status word layout.
    localparam int STAT_LEVEL_LSB = 0;
    localparam int STAT_LEVEL_W   = 4;
    localparam int STAT_EMPTY     = 4;
    localparam int STAT_AEMPTY    = 5;
    localparam int STAT_AFULL     = 6;
    localparam int STAT_FULL      = 7;
    localparam int STAT_OVERFLOW  = 8;

endpackage

`default_nettype wire

/* stream_pkg.sv */
`default_nettype none

package stream_pkg;

    // one byte of a frame, tagged when it closes the frame.
    typedef struct packed {
        logic       last;
        logic [7:0] data;
    } byte_entry_t;

    // per-frame result; the sum wraps modulo 2^16 and the count modulo 256.
    typedef struct packed {
        logic [15:0] sum;
        logic [7:0]  len;
    } frame_result_t;

    localparam int DATA_DEPTH   = 8;
    localparam int RESULT_DEPTH = 4;

    // almost-full is raised this many entries short of the depth.
    localparam int AFULL_LEVEL  = 1;
    // almost-empty is raised at or below this fill level.
    localparam int AEMPTY_LEVEL = 1;

    localparam int DATA_LEVEL_W = $clog2(DATA_DEPTH + 1);

endpackage

`default_nettype wire
